// File: common/fp_pkg.sv
// single-precision field widths, exponent constants, field struct and word union
`default_nettype none

package fp_pkg;

  localparam int SIGN_W = 1;
  localparam int EXP_W  = 8;
  localparam int MANT_W = 23;
  localparam int WORD_W = SIGN_W + EXP_W + MANT_W;

  // inputs whose reciprocal lands in the subnormal range
  localparam logic [EXP_W-1:0] EXP_SUBNORM_HI = 8'd254;
  localparam logic [EXP_W-1:0] EXP_SUBNORM_LO = 8'd253;

  // result exponent bases, input exponent is subtracted from these
  localparam logic [EXP_W-1:0] EXP_RECIP_EXACT   = 8'd254;
  localparam logic [EXP_W-1:0] EXP_RECIP_ROUNDED = 8'd253;

  typedef struct packed {
    logic [SIGN_W-1:0] sign;
    logic [EXP_W-1:0]  exponent;
    logic [MANT_W-1:0] mantissa;
  } float_fields_t;

  typedef union packed {
    logic [WORD_W-1:0] raw;
    float_fields_t     f;
  } float_t;

endpackage

`default_nettype wire

// File: common/recip_pkg.sv
// fixed-point datapath widths, shifts, pipeline state struct, seed function and latency
`default_nettype none

package recip_pkg;

  import fp_pkg::*;

  localparam int FIX_W         = 64;
  localparam int SEED_IDX_W    = 8;
  localparam int PROD_SHIFT    = 31;
  localparam int CORR_SHIFT    = 32;
  localparam int TARGET_LSB    = 8;
  localparam int RECIP_LATENCY = 4;

  typedef logic [FIX_W-1:0] fix_t;

  // state handed from one stage to the next
  typedef struct packed {
    logic   valid;
    float_t word;
    fix_t   x;
    fix_t   prod;
  } newton_state_t;

  // upper seed bits below the leading one of x0
  // seed(i) = floor(2^17 / (256 + i)) - 256, clamped to 255
  function automatic logic [SEED_IDX_W-1:0] seed_upper(input int unsigned idx);
    int unsigned num;
    int unsigned den;
    int unsigned q;
    num = 32'd1 << (2 * SEED_IDX_W + 1);
    den = (32'd1 << SEED_IDX_W) + idx;
    q   = num / den - (32'd1 << SEED_IDX_W);
    if (q > (32'd1 << SEED_IDX_W) - 1) begin
      q = (32'd1 << SEED_IDX_W) - 1;
    end
    return SEED_IDX_W'(q);
  endfunction

endpackage

`default_nettype wire

// File: recip/recip_seed_stage.sv
// seed stage: table estimate x0, target and first product, one register slice
`timescale 1ns/1ps
`default_nettype none

module recip_seed_stage
  import fp_pkg::*, recip_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          in_valid,
  input  float_t        in_word,
  output newton_state_t seed_state
);

  logic [SEED_IDX_W-1:0] seed_rom [2**SEED_IDX_W];
  logic [SEED_IDX_W-1:0] seed_idx;
  fix_t                  target;
  fix_t                  x0;

  // constant rom built from the seed rule
  for (genvar i = 0; i < 2**SEED_IDX_W; i++) begin : g_seed
    assign seed_rom[i] = seed_upper(i);
  end

  assign seed_idx = in_word.f.mantissa[MANT_W-1 -: SEED_IDX_W];

  // hidden one lands on bit 31
  assign target = {(FIX_W-MANT_W-1-TARGET_LSB)'(0), 1'b1, in_word.f.mantissa,
                   TARGET_LSB'(0)};

  // leading one sits just above the seed
  assign x0 = {(FIX_W-SEED_IDX_W-MANT_W)'(1), seed_rom[seed_idx], MANT_W'(0)};

  always_ff @(posedge clk) begin
    if (reset) begin
      seed_state.valid <= 1'b0;
    end else begin
      seed_state.valid <= in_valid;
    end
    seed_state.word.raw <= in_word.raw;
    seed_state.x        <= x0;
    seed_state.prod     <= (target * x0) >> PROD_SHIFT;
  end

endmodule

`default_nettype wire

// File: recip/recip_newton_stage.sv
// first newton correction and second product, two register slices
`timescale 1ns/1ps
`default_nettype none

module recip_newton_stage
  import fp_pkg::*, recip_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  newton_state_t seed_state,
  output newton_state_t iter_state
);

  fix_t   x1;
  logic   mid_valid;
  float_t mid_word;
  fix_t   mid_x;
  fix_t   target;

  // x1 = 2*x0 - x0 * (target * x0)
  assign x1 = (seed_state.x << 1) - ((seed_state.prod * seed_state.x) >> CORR_SHIFT);

  // slice 1 holds the corrected estimate
  always_ff @(posedge clk) begin
    if (reset) begin
      mid_valid <= 1'b0;
    end else begin
      mid_valid <= seed_state.valid;
    end
    mid_word.raw <= seed_state.word.raw;
    mid_x        <= x1;
  end

  // target again, straight from the carried word
  assign target = {(FIX_W-MANT_W-1-TARGET_LSB)'(0), 1'b1, mid_word.f.mantissa,
                   TARGET_LSB'(0)};

  // slice 2 holds the product for the next correction
  always_ff @(posedge clk) begin
    if (reset) begin
      iter_state.valid <= 1'b0;
    end else begin
      iter_state.valid <= mid_valid;
    end
    iter_state.word.raw <= mid_word.raw;
    iter_state.x        <= mid_x;
    iter_state.prod     <= (target * mid_x) >> PROD_SHIFT;
  end

endmodule

`default_nettype wire

// File: recip/recip_round_pack_stage.sv
// second newton correction, round to nearest even and result packing
`timescale 1ns/1ps
`default_nettype none

module recip_round_pack_stage
  import fp_pkg::*, recip_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  newton_state_t iter_state,
  output logic          out_valid,
  output float_t        out_word
);

  fix_t          x2;
  float_fields_t src;
  float_fields_t res;
  logic          ulp;
  logic          guard;
  logic          round;
  logic          sticky;
  logic          inc;
  logic          mant_zero;

  assign src = iter_state.word.f;
  assign x2  = (iter_state.x << 1) - ((iter_state.prod * iter_state.x) >> CORR_SHIFT);

  // grs just below the result lsb
  assign ulp    = x2[TARGET_LSB];
  assign guard  = x2[TARGET_LSB-1];
  assign round  = x2[TARGET_LSB-2];
  assign sticky = |x2[TARGET_LSB-3:0];
  assign inc    = guard & (round | sticky | ulp);

  assign mant_zero = (src.mantissa == '0);

  always_comb begin
    res.sign = src.sign;

    if (src.exponent == EXP_SUBNORM_HI) begin
      res.exponent = '0;
    end else if (mant_zero) begin
      res.exponent = EXP_RECIP_EXACT - src.exponent;
    end else begin
      res.exponent = EXP_RECIP_ROUNDED - src.exponent;
    end

    // subnormal results are truncated, one or two places down
    if (src.exponent == EXP_SUBNORM_HI) begin
      res.mantissa = x2[TARGET_LSB+2 +: MANT_W];
    end else if (src.exponent == EXP_SUBNORM_LO) begin
      res.mantissa = x2[TARGET_LSB+1 +: MANT_W];
    end else if (mant_zero) begin
      res.mantissa = '0;
    end else begin
      res.mantissa = x2[TARGET_LSB +: MANT_W] + MANT_W'(inc);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= iter_state.valid;
    end
    out_word.f <= res;
  end

endmodule

`default_nettype wire

// File: verilog/fp_recip.sv
// single-precision reciprocal top: seed, newton and round-pack stages
`timescale 1ns/1ps
`default_nettype none

module fp_recip
  import fp_pkg::*, recip_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   in_valid,
  input  float_t in_word,
  output logic   out_valid,
  output float_t out_word
);

  newton_state_t seed_state;
  newton_state_t iter_state;

  recip_seed_stage u_seed (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_word    (in_word),
    .seed_state (seed_state)
  );

  // two cycles here
  recip_newton_stage u_newton (
    .clk        (clk),
    .reset      (reset),
    .seed_state (seed_state),
    .iter_state (iter_state)
  );

  recip_round_pack_stage u_round_pack (
    .clk        (clk),
    .reset      (reset),
    .iter_state (iter_state),
    .out_valid  (out_valid),
    .out_word   (out_word)
  );

endmodule

`default_nettype wire

// File: test/fp_recip_assertions.sv
// bound assertions on reset clearing, valid latency and sign pass-through
`timescale 1ns/1ps
`default_nettype none

module fp_recip_assertions
  import fp_pkg::*, recip_pkg::*;
(
  input logic   clk,
  input logic   reset,
  input logic   in_valid,
  input float_t in_word,
  input logic   out_valid,
  input float_t out_word
);

  logic [2:0] warm;
  int         failures;

  // cycles since reset, saturating at the pipeline depth
  always_ff @(posedge clk) begin
    if (reset) begin
      warm <= '0;
    end else if (warm != 3'(RECIP_LATENCY)) begin
      warm <= warm + 3'd1;
    end
  end

  a_reset_clears: assert property (@(posedge clk) $past(reset) |-> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      failures++;
    end

  a_valid_latency: assert property (@(posedge clk) disable iff (reset)
    (warm == 3'(RECIP_LATENCY)) |-> out_valid == $past(in_valid, RECIP_LATENCY))
    else begin
      $error("out_valid does not follow in_valid by the pipeline latency");
      failures++;
    end

  a_sign_follows: assert property (@(posedge clk) disable iff (reset)
    (warm == 3'(RECIP_LATENCY) && out_valid) |->
      out_word.f.sign == $past(in_word.f.sign, RECIP_LATENCY))
    else begin
      $error("output sign differs from the input sign");
      failures++;
    end

endmodule

bind fp_recip fp_recip_assertions u_assertions (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .in_word   (in_word),
  .out_valid (out_valid),
  .out_word  (out_word)
);

`default_nettype wire

// File: test/recip_checker.sv
// checker: queues expected results and compares them with the DUT output
`timescale 1ns/1ps
`default_nettype none

module recip_checker
  import fp_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   out_valid,
  input  float_t out_word,
  input  logic   exp_valid,
  input  float_t exp_word,
  input  int     exp_tol,
  output int     errors,
  output int     checks,
  output int     pending
);

  float_t exp_q [$];
  int     tol_q [$];
  int     err_cnt;
  int     chk_cnt;

  // distance between magnitudes, in units of the last place
  function automatic int mag_diff(float_t a, float_t b);
    int ma;
    int mb;
    ma = int'(a.raw[WORD_W-2:0]);
    mb = int'(b.raw[WORD_W-2:0]);
    return (ma > mb) ? ma - mb : mb - ma;
  endfunction

  always @(posedge clk) begin
    float_t want;
    int     tol;
    if (!reset) begin
      if (exp_valid) begin
        exp_q.push_back(exp_word);
        tol_q.push_back(exp_tol);
      end
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("output %h at %0t came with no expected value queued",
                   out_word.raw, $time);
          err_cnt++;
        end else begin
          want = exp_q.pop_front();
          tol  = tol_q.pop_front();
          chk_cnt++;
          if (out_word.f.sign != want.f.sign || mag_diff(out_word, want) > tol) begin
            $display("mismatch at %0t: out_word got %h expected %h",
                     $time, out_word.raw, want.raw);
            err_cnt++;
          end
        end
      end
    end
    errors  <= err_cnt;
    checks  <= chk_cnt;
    pending <= exp_q.size();
  end

  task automatic report_leftover(output int leftover);
    leftover = exp_q.size();
    if (leftover != 0) begin
      $display("%0d expected results never came out of the DUT", leftover);
    end
  endtask

endmodule

`default_nettype wire

// File: test/tb_fp_recip.sv
// testbench top: clock generator, stimulus table, row loop and final report
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;
  always #2 clk = ~clk;

endmodule

module tb_fp_recip
  import fp_pkg::*, recip_pkg::*;
();

  localparam int N_RANDOM      = 40;
  localparam int N_ROWS        = 16 + N_RANDOM;
  localparam int DRAIN_TIMEOUT = 64;
  localparam int WATCHDOG_NS   = 20000;

  logic   clk;
  logic   reset;
  logic   in_valid;
  float_t in_word;
  logic   out_valid;
  float_t out_word;
  logic   exp_valid;
  float_t exp_word;
  int     exp_tol;
  int     errors;
  int     checks;
  int     pending;

  float_t in_tab  [N_ROWS];
  float_t exp_tab [N_ROWS];
  int     tol_tab [N_ROWS];
  int     n_rows;
  int     tb_errors;

  tb_clock u_clock (.clk(clk));

  fp_recip dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .out_valid (out_valid),
    .out_word  (out_word)
  );

  recip_checker chk (
    .clk       (clk),
    .reset     (reset),
    .out_valid (out_valid),
    .out_word  (out_word),
    .exp_valid (exp_valid),
    .exp_word  (exp_word),
    .exp_tol   (exp_tol),
    .errors    (errors),
    .checks    (checks),
    .pending   (pending)
  );

  function automatic float_t make_word(logic s, int e, logic [MANT_W-1:0] m);
    float_t w;
    w.raw = {s, e[EXP_W-1:0], m};
    return w;
  endfunction

  // true reciprocal through double precision, rounded back to single
  function automatic float_t ref_recip(float_t a);
    logic [63:0] d;
    logic [52:0] full;
    logic [31:0] m;
    int          e;
    real         r;
    float_t      res;
    e = int'(a.f.exponent) - 127 + 1023;
    d = {a.f.sign, e[10:0], a.f.mantissa, 29'd0};
    r = 1.0 / $bitstoreal(d);
    d = $realtobits(r);
    e = int'(d[62:52]) - 1023 + 127;
    if (e >= 1) begin
      res.raw = {d[63], e[7:0], d[51:29]} + {31'd0, d[28]};
    end else begin
      // subnormal, keep one extra bit for rounding
      full = {1'b1, d[51:0]} >> (29 - e);
      m = 32'(full >> 1) + {31'd0, full[0]};
      res.raw = {d[63], m[30:0]};
    end
    return res;
  endfunction

  task automatic add_row(input float_t a, input int tol);
    in_tab[n_rows]  = a;
    exp_tab[n_rows] = ref_recip(a);
    tol_tab[n_rows] = tol;
    n_rows++;
  endtask

  task automatic build_table();
    logic              s;
    int                e;
    logic [MANT_W-1:0] m;
    for (int neg = 0; neg < 2; neg++) begin
      s = (neg == 1);
      add_row(make_word(s, 1, '0), 0);
      add_row(make_word(s, 127, '0), 0);
      add_row(make_word(s, 200, '0), 0);
      add_row(make_word(s, 252, '0), 0);
      // exactly 2^-127
      add_row(make_word(s, 254, '0), 0);
      // 1.5 and 1.0 times 2^126
      add_row(make_word(s, 253, 23'h400000), 1);
      add_row(make_word(s, 253, '0), 1);
      add_row(make_word(s, 254, 23'h200000), 1);
    end
    for (int i = 0; i < N_RANDOM; i++) begin
      s = 1'($urandom % 2);
      e = 1 + int'($urandom % 252);
      m = MANT_W'($urandom);
      add_row(make_word(s, e, m), 1);
    end
  endtask

  initial begin
    int idle;
    int waited;
    int leftover;
    int total;
    void'($urandom(76));
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_word   = '0;
    exp_valid = 1'b0;
    exp_word  = '0;
    exp_tol   = 0;
    tb_errors = 0;
    n_rows    = 0;
    build_table();
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      in_valid  <= 1'b1;
      in_word   <= in_tab[i];
      exp_valid <= 1'b1;
      exp_word  <= exp_tab[i];
      exp_tol   <= tol_tab[i];
      // idle gaps of one to four cycles now and then
      idle = (i % 6 == 5) ? 1 + (i / 6) % 4 : 0;
      for (int j = 0; j < idle; j++) begin
        @(posedge clk);
        in_valid  <= 1'b0;
        exp_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid  <= 1'b0;
    exp_valid <= 1'b0;
    @(posedge clk);

    waited = 0;
    while (pending != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (pending != 0) begin
      $display("timed out after %0d cycles with %0d results still due", waited, pending);
      tb_errors++;
    end

    // items in flight when reset hits must never come out
    @(posedge clk);
    in_valid <= 1'b1;
    in_word  <= in_tab[0];
    repeat (3) @(posedge clk);
    reset <= 1'b1;
    repeat (2) @(posedge clk);
    reset    <= 1'b0;
    in_valid <= 1'b0;
    repeat (2 * RECIP_LATENCY) @(posedge clk);
    chk.report_leftover(leftover);

    total = tb_errors + errors + leftover + dut.u_assertions.failures;
    $display("rows %0d, checked %0d, errors %0d", n_rows, checks, total);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("simulation ran past its time limit");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
common/fp_pkg.sv
common/recip_pkg.sv
recip/recip_seed_stage.sv
recip/recip_newton_stage.sv
recip/recip_round_pack_stage.sv
verilog/fp_recip.sv
test/fp_recip_assertions.sv
test/recip_checker.sv
test/tb_fp_recip.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= tb_fp_recip
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "TEST PASS" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
